// ==== hdl/axi_data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_settings.svh"

module axi_data_ram import lsu_pkg::*; (
	input  logic    clock,
	input  logic    rst_n,
	input  axi_ax_t ar,
	input  logic    arvalid,
	output logic    arready,
	output axi_r_t  r,
	output logic    rvalid,
	input  logic    rready,
	input  axi_ax_t aw,
	input  logic    awvalid,
	output logic    awready,
	input  axi_w_t  w,
	input  logic    wvalid,
	output logic    wready,
	output resp_t   bresp,
	output logic    bvalid,
	input  logic    bready
);

	localparam int IDX_W = $clog2(`LSU_RAM_WORDS);
	localparam int CNT_W = $clog2(`LSU_RAM_LATENCY + 1);

	bus_data_t        mem [`LSU_RAM_WORDS];
	bus_data_t        rdata_q;
	logic             pend;
	logic             is_read;
	logic [CNT_W-1:0] cnt;
	logic             aw_got;
	logic             w_got;
	addr_t            aw_addr_q;
	axi_w_t           w_q;
	addr_t            wr_addr;
	axi_w_t           wr_beat;
	logic [IDX_W-1:0] wr_idx;
	logic             wr_go;
	logic             ar_fire;
	logic             aw_fire;
	logic             w_fire;

	function automatic logic [IDX_W-1:0] word_idx(input addr_t a);
		addr_t off;
		off = a - `LSU_RAM_BASE;
		return off[IDX_W+2:3];
	endfunction

	assign arready = ~pend;
	assign awready = ~pend & ~aw_got;
	assign wready  = ~pend & ~w_got;

	assign ar_fire = arvalid & arready;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;

	// aw and w may arrive on different cycles
	assign wr_addr = aw_got ? aw_addr_q : aw.addr;
	assign wr_beat = w_got ? w_q : w;
	assign wr_idx  = word_idx(wr_addr);
	assign wr_go   = (aw_got | aw_fire) & (w_got | w_fire);

	assign r.data = rdata_q;
	assign r.resp = `LSU_RESP_OKAY;
	assign bresp  = `LSU_RESP_OKAY;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pend    <= 1'b0;
			is_read <= 1'b0;
			cnt     <= '0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			if (aw_fire && !wr_go)
				aw_got <= 1'b1;
			if (w_fire && !wr_go)
				w_got <= 1'b1;
			if (ar_fire || wr_go) begin
				pend    <= 1'b1;
				is_read <= ar_fire;
				cnt     <= CNT_W'(`LSU_RAM_LATENCY - 1);
				if (wr_go) begin
					aw_got <= 1'b0;
					w_got  <= 1'b0;
				end
			end else if (pend) begin
				if (cnt != '0) begin
					cnt <= cnt - 1'b1;
				end else if (!rvalid && !bvalid) begin
					rvalid <= is_read; // held until accepted
					bvalid <= ~is_read;
				end
			end
			if ((rvalid && rready) || (bvalid && bready)) begin
				pend   <= 1'b0;
				rvalid <= 1'b0;
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire)
			aw_addr_q <= aw.addr;
		if (w_fire)
			w_q <= w;
		if (ar_fire)
			rdata_q <= mem[word_idx(ar.addr)];
		if (wr_go) begin
			for (int i = 0; i < 8; i++) begin
				if (wr_beat.strb[i])
					mem[wr_idx][i*8 +: 8] <= wr_beat.data[i*8 +: 8];
			end
		end
	end

endmodule

// ==== hdl/load_extend.sv ====
`timescale 1ns/1ps

module load_extend import lsu_pkg::*; (
	input  bus_data_t  rdata,
	input  logic [2:0] addr_low,
	input  funct3_t    funct3,
	output xlen_t      value
);

	xlen_t word;
	xlen_t shifted;

	assign word    = addr_low[2] ? rdata[63:32] : rdata[31:0]; // upper or lower half
	assign shifted = word >> {addr_low[1:0], 3'b000};

	always_comb begin
		case (funct3)
			3'b000:  value = {{24{shifted[7]}}, shifted[7:0]};   // lb
			3'b001:  value = {{16{shifted[15]}}, shifted[15:0]}; // lh
			3'b100:  value = {24'h0, shifted[7:0]};              // lbu
			3'b101:  value = {16'h0, shifted[15:0]};             // lhu
			default: value = shifted;                            // lw
		endcase
	end

endmodule

// ==== hdl/lsu_core.sv ====
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_core import lsu_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     busy,
	output logic     done,
	output xlen_t    load_val,
	output axi_ax_t  ar,
	output logic     arvalid,
	input  logic     arready,
	input  axi_r_t   r,
	input  logic     rvalid,
	output logic     rready,
	output axi_ax_t  aw,
	output logic     awvalid,
	input  logic     awready,
	output axi_w_t   w,
	output logic     wvalid,
	input  logic     wready,
	input  resp_t    bresp,
	input  logic     bvalid,
	output logic     bready
);

	lsu_req_t   req_q;
	lsu_state_t state;
	axi_ax_t    ax;
	addr_t      addr;
	xlen_t      ext_val;
	logic       ar_fire;
	logic       r_fire;
	logic       aw_fire;
	logic       w_fire;
	logic       b_fire;
	logic       aw_left;
	logic       w_left;

	assign addr    = req_q.src1 + req_q.imm;
	assign ax.addr = addr;
	assign ax.size = {1'b0, req_q.funct3[1:0]}; // 0 byte, 1 half, 2 word
	assign ar      = ax;
	assign aw      = ax;

	assign busy   = state != IDLE;
	assign rready = state == RD_DATA;
	assign bready = state == WR_RESP;

	assign ar_fire = arvalid & arready;
	assign r_fire  = rvalid & rready;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;
	assign b_fire  = bvalid & bready;
	assign aw_left = awvalid & ~awready; // still waiting after this edge
	assign w_left  = wvalid & ~wready;

	load_extend u_load_extend (
		.rdata    (r.data),
		.addr_low (addr[2:0]),
		.funct3   (req_q.funct3),
		.value    (ext_val)
	);

	store_lane u_store_lane (
		.src2     (req_q.src2),
		.addr_low (addr[2:0]),
		.funct3   (req_q.funct3),
		.w        (w)
	);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= IDLE;
			arvalid  <= 1'b0;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			done     <= 1'b0;
			load_val <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (req_valid) begin
						state   <= req.is_store ? WR_REQ : RD_ADDR;
						arvalid <= ~req.is_store;
						awvalid <= req.is_store;
						wvalid  <= req.is_store;
					end
				end
				RD_ADDR: begin
					if (ar_fire) begin
						arvalid <= 1'b0;
						state   <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (r_fire) begin
						if (r.resp == `LSU_RESP_OKAY) begin
							load_val <= ext_val;
							done     <= 1'b1;
							state    <= IDLE;
						end else begin
							arvalid <= 1'b1; // reissue the read
							state   <= RD_ADDR;
						end
					end
				end
				WR_REQ: begin
					if (aw_fire)
						awvalid <= 1'b0;
					if (w_fire)
						wvalid <= 1'b0;
					if (!aw_left && !w_left)
						state <= WR_RESP;
				end
				WR_RESP: begin
					if (b_fire) begin
						if (bresp == `LSU_RESP_OKAY) begin
							done  <= 1'b1;
							state <= IDLE;
						end else begin
							awvalid <= 1'b1; // reissue the write
							wvalid  <= 1'b1;
							state   <= WR_REQ;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && req_valid)
			req_q <= req; // held for the whole access
	end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] xlen_t;
	typedef logic [63:0] bus_data_t;
	typedef logic [7:0]  strb_t;
	typedef logic [1:0]  resp_t;
	typedef logic [2:0]  funct3_t;

	typedef struct packed {
		logic    is_store;
		funct3_t funct3;
		xlen_t   src1;
		xlen_t   src2;
		xlen_t   imm;
	} lsu_req_t;

	// shared by ar and aw
	typedef struct packed {
		addr_t      addr;
		logic [2:0] size;
	} axi_ax_t;

	typedef struct packed {
		bus_data_t data;
		strb_t     strb;
	} axi_w_t;

	typedef struct packed {
		bus_data_t data;
		resp_t     resp;
	} axi_r_t;

	typedef enum logic [2:0] {
		IDLE,
		RD_ADDR,
		RD_DATA,
		WR_REQ,
		WR_RESP
	} lsu_state_t;

endpackage

// ==== hdl/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data RAM geometry, in 64-bit words
`define LSU_RAM_WORDS 256

// cycles from accepted address to response
`define LSU_RAM_LATENCY 2

// byte address of word 0
`define LSU_RAM_BASE 32'h8000_0000

`define LSU_RESP_OKAY 2'b00

`endif

// ==== hdl/lsu_unit.sv ====
`timescale 1ns/1ps

module lsu_unit import lsu_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     busy,
	output logic     done,
	output xlen_t    load_val
);

	axi_ax_t ar;
	logic    arvalid;
	logic    arready;
	axi_r_t  r;
	logic    rvalid;
	logic    rready;
	axi_ax_t aw;
	logic    awvalid;
	logic    awready;
	axi_w_t  w;
	logic    wvalid;
	logic    wready;
	resp_t   bresp;
	logic    bvalid;
	logic    bready;

	lsu_core u_lsu_core (
		.clock, .rst_n, .req, .req_valid, .busy, .done, .load_val,
		.ar, .arvalid, .arready,
		.r, .rvalid, .rready,
		.aw, .awvalid, .awready,
		.w, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

	axi_data_ram u_axi_data_ram (
		.clock, .rst_n,
		.ar, .arvalid, .arready,
		.r, .rvalid, .rready,
		.aw, .awvalid, .awready,
		.w, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

endmodule

// ==== hdl/store_lane.sv ====
`timescale 1ns/1ps

module store_lane import lsu_pkg::*; (
	input  xlen_t      src2,
	input  logic [2:0] addr_low,
	input  funct3_t    funct3,
	output axi_w_t     w
);

	strb_t mask;

	always_comb begin
		case (funct3[1:0])
			2'b00:   mask = 8'h01; // sb
			2'b01:   mask = 8'h03; // sh
			default: mask = 8'h0f; // sw
		endcase
	end

	// byte lanes follow the low address bits
	assign w.strb = mask << addr_low;
	assign w.data = bus_data_t'(src2) << {addr_low, 3'b000};

endmodule

// ==== lsu_unit.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/load_extend.sv
hdl/store_lane.sv
hdl/lsu_core.sv
hdl/axi_data_ram.sv
hdl/lsu_unit.sv
verification/lsu_unit_assertions.sv
verification/lsu_unit_tb.sv

// ==== verification/lsu_unit_assertions.sv ====
`timescale 1ns/1ps

module lsu_unit_assertions import lsu_pkg::*; (
	input logic       clock,
	input logic       rst_n,
	input lsu_state_t state,
	input logic       busy,
	input logic       done,
	input axi_ax_t    ar,
	input logic       arvalid,
	input logic       arready,
	input axi_r_t     r,
	input logic       rvalid,
	input logic       rready,
	input axi_ax_t    aw,
	input logic       awvalid,
	input logic       awready,
	input axi_w_t     w,
	input logic       wvalid,
	input logic       wready,
	input logic       bvalid,
	input logic       bready
);

	int fail_count = 0;

	// a valid holds until its transfer and drops right after it
	ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid |=> ($past(arready) ? !arvalid : (arvalid && $stable(ar))))
	else begin
		$error("arvalid or ar changed before arready, or arvalid stayed high after it");
		fail_count++;
	end

	aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid |=> ($past(awready) ? !awvalid : (awvalid && $stable(aw))))
	else begin
		$error("awvalid or aw changed before awready, or awvalid stayed high after it");
		fail_count++;
	end

	w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wvalid |=> ($past(wready) ? !wvalid : (wvalid && $stable(w))))
	else begin
		$error("wvalid or w changed before wready, or wvalid stayed high after it");
		fail_count++;
	end

	r_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rvalid |=> ($past(rready) ? !rvalid : (rvalid && $stable(r))))
	else begin
		$error("rvalid or r changed before rready, or rvalid stayed high after it");
		fail_count++;
	end

	b_hold: assert property (@(posedge clock) disable iff (!rst_n)
		bvalid |=> ($past(bready) ? !bvalid : bvalid))
	else begin
		$error("bvalid dropped before bready, or stayed high after it");
		fail_count++;
	end

	// done is registered from the response transfer
	done_after_xfer: assert property (@(posedge clock) disable iff (!rst_n)
		done |-> $past((rvalid && rready) || (bvalid && bready)))
	else begin
		$error("done without an r or b transfer in the cycle before");
		fail_count++;
	end

	idle_not_busy: assert property (@(posedge clock) disable iff (!rst_n)
		state == IDLE |-> !busy && !arvalid && !awvalid && !wvalid)
	else begin
		$error("busy or a request valid high while the FSM is idle");
		fail_count++;
	end

endmodule

bind lsu_core lsu_unit_assertions u_assert (.*);

// ==== verification/lsu_unit_tb.sv ====
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_unit_tb import lsu_pkg::*; ();

	localparam int REQ_LIMIT   = 40;
	localparam int CYCLE_LIMIT = REQ_LIMIT * (`LSU_RAM_LATENCY + 6) + 50;
	localparam int BYTES       = `LSU_RAM_WORDS * 8;

	logic     clock;
	logic     rst_n;
	lsu_req_t req;
	logic     req_valid;
	logic     busy;
	logic     done;
	xlen_t    load_val;

	logic [7:0] model [BYTES]; // byte image of the RAM
	xlen_t      last_load;
	int         cycles;
	int         value_errors;
	int         protocol_errors;
	int         done_count;
	int         accepted;

	lsu_unit dut0 (.clock, .rst_n, .req, .req_valid, .busy, .done, .load_val);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(negedge clock) begin
		if (rst_n && done)
			done_count++;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	function automatic int byte_offset(input addr_t addr);
		return int'(addr - `LSU_RAM_BASE);
	endfunction

	function automatic void model_store(input addr_t addr, input funct3_t funct3,
			input xlen_t data);
		for (int i = 0; i < (1 << funct3[1:0]); i++)
			model[byte_offset(addr) + i] = data[i*8 +: 8]; // little endian
	endfunction

	function automatic xlen_t expect_load(input addr_t addr, input funct3_t funct3);
		int    n;
		xlen_t raw;
		n = 1 << funct3[1:0];
		raw = '0;
		for (int i = 0; i < n; i++)
			raw[i*8 +: 8] = model[byte_offset(addr) + i];
		if (funct3[2] || n == 4)
			return raw; // unsigned or full word
		return n == 1 ? {{24{raw[7]}}, raw[7:0]} : {{16{raw[15]}}, raw[15:0]};
	endfunction

	task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
		assert (act === exp)
		else begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_done_count(input string name);
		assert (done_count == accepted)
		else begin
			$display("%s: saw %0d done pulses for %0d accepted requests",
				name, done_count, accepted);
			protocol_errors++;
		end
	endtask

	task automatic run_request(input string name, input logic is_store, input funct3_t funct3,
			input addr_t addr, input xlen_t data, input logic poke);
		lsu_req_t r;
		xlen_t    exp;
		r.is_store = is_store;
		r.funct3   = funct3;
		r.imm      = $urandom_range(0, 255);
		r.src1     = addr - r.imm;
		r.src2     = data;
		if (is_store) begin
			model_store(addr, funct3, data);
			exp = last_load; // stores leave load_val alone
		end else begin
			exp = expect_load(addr, funct3);
		end
		@(posedge clock);
		req       <= r;
		req_valid <= 1'b1;
		@(posedge clock);
		req_valid <= 1'b0;
		accepted++;
		@(negedge clock);
		assert (busy)
		else begin
			$display("%s: busy stayed low after an accepted request", name);
			protocol_errors++;
		end
		if (poke) begin
			@(posedge clock);
			req_valid <= 1'b1; // must be ignored while busy
			@(posedge clock);
			req_valid <= 1'b0;
		end
		do
			@(negedge clock);
		while (!done);
		check_value(name, exp, load_val);
		last_load = exp;
		@(posedge clock);
		check_done_count(name);
	endtask

	initial begin
		addr_t a;
		void'($urandom(32'ha942_0334));
		value_errors    = 0;
		protocol_errors = 0;
		done_count      = 0;
		accepted        = 0;
		last_load       = '0;
		rst_n           = 1'b0;
		req             = '0;
		req_valid       = 1'b0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_value("reset busy", '0, xlen_t'(busy));
		check_value("reset done", '0, xlen_t'(done));
		check_value("reset load_val", '0, load_val);

		for (int k = 0; k < 2; k++) begin
			a = `LSU_RAM_BASE + ($urandom_range(0, `LSU_RAM_WORDS - 1) << 3);
			run_request("sw lower", 1'b1, 3'b010, a, $urandom, 1'b0);
			run_request("sw upper", 1'b1, 3'b010, a + 4, $urandom, 1'b0);
			run_request("lw lower", 1'b0, 3'b010, a, '0, 1'b0);
			run_request("lw upper", 1'b0, 3'b010, a + 4, '0, 1'b0);
		end

		a = `LSU_RAM_BASE + ($urandom_range(0, `LSU_RAM_WORDS - 1) << 3);
		run_request("sw lane base", 1'b1, 3'b010, a, $urandom, 1'b0);
		for (int k = 0; k < 4; k++) begin
			run_request("sb lane", 1'b1, 3'b000, a + k, $urandom, 1'b0);
			run_request("lw after sb", 1'b0, 3'b010, a, '0, 1'b0);
		end
		for (int k = 0; k < 4; k += 2) begin
			run_request("sh lane", 1'b1, 3'b001, a + k, $urandom, 1'b0);
			run_request("lw after sh", 1'b0, 3'b010, a, '0, 1'b0);
		end

		// bytes 7f 01 ff 80, halves 017f and 80ff
		a = `LSU_RAM_BASE + ($urandom_range(0, `LSU_RAM_WORDS - 1) << 3) + 4;
		run_request("sw pattern", 1'b1, 3'b010, a, 32'h80ff_017f, 1'b0);
		for (int k = 0; k < 4; k++)
			run_request("lb", 1'b0, 3'b000, a + k, '0, 1'b0);
		run_request("lbu", 1'b0, 3'b100, a + 2, '0, 1'b0);
		run_request("lbu", 1'b0, 3'b100, a + 3, '0, 1'b0);
		for (int k = 0; k < 4; k += 2) begin
			run_request("lh", 1'b0, 3'b001, a + k, '0, 1'b0);
			run_request("lhu", 1'b0, 3'b101, a + k, '0, 1'b0);
		end

		run_request("sw while busy", 1'b1, 3'b010, a, $urandom, 1'b1);
		run_request("lw while busy", 1'b0, 3'b010, a, '0, 1'b1);
		repeat (4) @(posedge clock);
		check_done_count("final");

		$display("value errors: %0d, protocol errors: %0d, assertion failures: %0d",
			value_errors, protocol_errors, dut0.u_lsu_core.u_assert.fail_count);
		if (value_errors + protocol_errors + dut0.u_lsu_core.u_assert.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
